//--- hdl/vector_lane_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// shared types and sizes for the vector lane group
// import with a wildcard in the module header of every lane file
// lane_req_t goes in, lane_resp_t comes out of each lane
//~~~~~~~~~~~~~~~~~~~~

package vector_lane_pkg;

  localparam int LANES      = 4;   // lanes in the group
  localparam int XLEN       = 32;  // element width
  localparam int DIV_CYCLES = 32;  // one quotient bit per iteration

  // functional unit select, also used as the result tag
  typedef enum logic [1:0] {
    ARITH = 2'd0,
    MUL   = 2'd1,
    DIV   = 2'd2
  } fu_type_t;

  // operation within the selected unit
  typedef enum logic [4:0] {
    ADD    = 5'd0,
    SUB    = 5'd1,
    AND    = 5'd2,
    OR     = 5'd3,
    XOR    = 5'd4,
    SLL    = 5'd5,
    SRL    = 5'd6,
    SRA    = 5'd7,
    MIN    = 5'd8,   // signed
    MINU   = 5'd9,
    MAX    = 5'd10,  // signed
    MAXU   = 5'd11,
    MULLO  = 5'd12,  // low word, sign does not matter
    MULHI  = 5'd13,  // high word, signed x signed
    MULHIU = 5'd14,  // high word, unsigned x unsigned
    DIVS   = 5'd15,
    DIVU   = 5'd16,
    REMS   = 5'd17,
    REMU   = 5'd18
  } alu_op_t;

  // issue bundle, op shared by all lanes, operands per lane
  typedef struct packed {
    fu_type_t        fu_type;
    alu_op_t         op;
    logic [XLEN-1:0] vs1;
    logic [XLEN-1:0] vs2;
  } lane_req_t;

  // tagged result, one per lane
  typedef struct packed {
    logic            valid;
    fu_type_t        fu_type;    // which unit produced it
    logic [XLEN-1:0] result;
    logic            exception;  // divide by zero
  } lane_resp_t;

endpackage

//--- hdl/arithmetic_unit.sv
//~~~~~~~~~~~~~~~~~~~~
// single cycle integer ALU for one vector element
// start with an ARITH request, result and done follow one cycle later
// shifts use the low 5 bits of vs2
//~~~~~~~~~~~~~~~~~~~~

module arithmetic_unit import vector_lane_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            start,
  input  lane_req_t       req,
  output logic            done,
  output logic [XLEN-1:0] result
);

  logic [XLEN-1:0] alu_res;  // next result
  logic [4:0]      shamt;
  logic            lt_s;     // vs1 < vs2 signed
  logic            lt_u;     // vs1 < vs2 unsigned

  assign shamt = req.vs2[4:0];
  assign lt_s  = $signed(req.vs1) < $signed(req.vs2);
  assign lt_u  = req.vs1 < req.vs2;

  always_comb begin
    case (req.op)
      ADD:     alu_res = req.vs1 + req.vs2;
      SUB:     alu_res = req.vs1 - req.vs2;
      AND:     alu_res = req.vs1 & req.vs2;
      OR:      alu_res = req.vs1 | req.vs2;
      XOR:     alu_res = req.vs1 ^ req.vs2;
      SLL:     alu_res = req.vs1 << shamt;
      SRL:     alu_res = req.vs1 >> shamt;
      SRA:     alu_res = $unsigned($signed(req.vs1) >>> shamt);  // keep sign bits
      MIN:     alu_res = lt_s ? req.vs1 : req.vs2;
      MINU:    alu_res = lt_u ? req.vs1 : req.vs2;
      MAX:     alu_res = lt_s ? req.vs2 : req.vs1;
      MAXU:    alu_res = lt_u ? req.vs2 : req.vs1;
      default: alu_res = '0;  // non arith op, never started
    endcase
  end

  // done strobe, cleared on reset
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // payload only loads on start
  always_ff @(posedge CLK) begin
    if (start) begin
      result <= alu_res;
    end
  end

  // the lane decoder must only start this unit with an ALU op
  assert property (@(posedge CLK) disable iff (!rst_n)
    start |-> req.fu_type == ARITH &&
              req.op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
                             MIN, MINU, MAX, MAXU})
    else $error("arithmetic_unit started with op %s", req.op.name());

endmodule

//--- hdl/multiply_unit.sv
//~~~~~~~~~~~~~~~~~~~~
// two stage pipelined 32x32 multiplier
// one start per cycle, done and result two cycles after start
// MULLO gives the low word, MULHI and MULHIU the high word
//~~~~~~~~~~~~~~~~~~~~

module multiply_unit import vector_lane_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            start,
  input  lane_req_t       req,
  output logic            done,
  output logic [XLEN-1:0] result
);

  logic                   ext_s;   // sign extend operands
  logic                   v1;      // stage 1 valid
  logic                   hi1;     // stage 1 wants high word
  logic signed [XLEN:0]   a1, b1;  // extended operands
  logic signed [2*XLEN+1:0] prod;  // 66 bit signed product

  assign ext_s = req.op != MULHIU;  // MULLO low word is the same either way

  // stage 1 operand capture
  always_ff @(posedge CLK) begin
    a1  <= {ext_s & req.vs1[XLEN-1], req.vs1};
    b1  <= {ext_s & req.vs2[XLEN-1], req.vs2};
    hi1 <= req.op != MULLO;
  end

  assign prod = a1 * b1;

  // stage 2 word select
  always_ff @(posedge CLK) begin
    result <= hi1 ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
  end

  // valid bit travels alongside the data
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      v1   <= 1'b0;
      done <= 1'b0;
    end else begin
      v1   <= start;
      done <= v1;
    end
  end

  // fixed two cycle latency, the lane merge depends on it
  assert property (@(posedge CLK) disable iff (!rst_n)
    start |-> ##2 done)
    else $error("multiply_unit done missing two cycles after start");

endmodule

//--- hdl/divide_unit.sv
//~~~~~~~~~~~~~~~~~~~~
// radix-2 restoring divider, signed and unsigned
// busy rises the cycle after start, done pulses 33 cycles after start
// result stays until the next start and div_zero pulses with done
//~~~~~~~~~~~~~~~~~~~~

module divide_unit import vector_lane_pkg::*; (
  input  logic            CLK,
  input  logic            rst_n,
  input  logic            start,
  input  lane_req_t       req,
  output logic            done,
  output logic            busy,
  output logic [XLEN-1:0] result,
  output logic            div_zero
);

  localparam int CW = $clog2(DIV_CYCLES);

  logic            sgn;          // signed op
  logic            a_neg, b_neg;
  logic            b_zero;
  logic [XLEN-1:0] a_mag, b_mag;
  logic [CW-1:0]   cnt;          // iteration index
  logic [XLEN-1:0] quo;          // dividend in, quotient out
  logic [XLEN-1:0] rem;          // partial remainder
  logic [XLEN-1:0] dvsr;
  logic            neg_q, neg_r; // sign fixes at the end
  logic            want_rem;
  logic            dz;
  logic [XLEN:0]   rem_sh;       // shifted remainder, one extra bit
  logic [XLEN:0]   diff;

  assign sgn    = req.op inside {DIVS, REMS};
  assign a_neg  = sgn & req.vs1[XLEN-1];
  assign b_neg  = sgn & req.vs2[XLEN-1];
  assign b_zero = req.vs2 == '0;
  assign a_mag  = a_neg ? -req.vs1 : req.vs1;  // most negative maps to 2^31
  assign b_mag  = b_neg ? -req.vs2 : req.vs2;

  assign rem_sh = {rem, quo[XLEN-1]};
  assign diff   = rem_sh - {1'b0, dvsr};  // msb set means no subtract

  // operand capture then one shift-subtract step per cycle
  always_ff @(posedge CLK) begin
    if (start) begin
      quo      <= a_mag;
      rem      <= '0;
      dvsr     <= b_mag;
      neg_q    <= (a_neg ^ b_neg) & ~b_zero;  // x/0 keeps all ones quotient
      neg_r    <= a_neg;                      // remainder follows dividend
      want_rem <= req.op inside {REMS, REMU};
      dz       <= b_zero;
    end else if (busy) begin
      if (!diff[XLEN]) begin
        rem <= diff[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b1};
      end else begin
        rem <= rem_sh[XLEN-1:0];
        quo <= {quo[XLEN-2:0], 1'b0};
      end
    end
  end

  // busy, iteration count and done strobe
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      div_zero <= 1'b0;
      cnt      <= '0;
    end else begin
      done     <= 1'b0;
      div_zero <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == CW'(DIV_CYCLES - 1)) begin  // last shift-subtract step
          busy     <= 1'b0;
          done     <= 1'b1;
          div_zero <= dz;
        end
      end
    end
  end

  // 2^31 / 1 without a sign fix already gives the overflow quotient
  assign result = want_rem ? (neg_r ? -rem : rem)
                           : (neg_q ? -quo : quo);

  assert property (@(posedge CLK) disable iff (!rst_n)
    start |-> !busy)
    else $error("divide_unit started while busy");

endmodule

//--- hdl/vector_lane.sv
//~~~~~~~~~~~~~~~~~~~~
// one vector lane with arithmetic, multiply and divide units
// issue strobes a request into the unit named by fu_type
// results merge into one tagged stream, a divide result waits for a free slot
// busy covers a running divide and a waiting divide result
//~~~~~~~~~~~~~~~~~~~~

module vector_lane import vector_lane_pkg::*; (
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       issue,
  input  lane_req_t  req,
  output lane_resp_t resp,
  output logic       busy
);

  logic            start_a, start_m, start_d;
  logic            a_done, m_done, d_done;
  logic [XLEN-1:0] a_result, m_result, d_result;
  logic            d_busy;
  logic            d_zero;
  logic            hold_valid;      // divide result parked
  logic [XLEN-1:0] hold_result;
  logic            hold_exc;
  logic            slot_free;       // no arith or mul result this cycle
  logic            div_pending;
  logic            div_out;         // divide result goes out now

  // decode, one start per issue
  assign start_a = issue && req.fu_type == ARITH;
  assign start_m = issue && req.fu_type == MUL;
  assign start_d = issue && req.fu_type == DIV;

  arithmetic_unit u_arithmetic_unit (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .start  (start_a),
    .req    (req),
    .done   (a_done),
    .result (a_result)
  );

  multiply_unit u_multiply_unit (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .start  (start_m),
    .req    (req),
    .done   (m_done),
    .result (m_result)
  );

  divide_unit u_divide_unit (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .start    (start_d),
    .req      (req),
    .done     (d_done),
    .busy     (d_busy),
    .result   (d_result),
    .div_zero (d_zero)
  );

  assign slot_free   = !a_done && !m_done;
  assign div_pending = d_done || hold_valid;
  assign div_out     = div_pending && slot_free;

  // one entry hold slot for the divide result
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      hold_valid <= 1'b0;
    end else if (d_done && !slot_free) begin
      hold_valid <= 1'b1;       // collided, park it
    end else if (div_out) begin
      hold_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (d_done) begin
      hold_result <= d_result;
      hold_exc    <= d_zero;
    end
  end

  // result merge, arith and mul never overlap
  always_comb begin
    resp = '0;
    if (a_done) begin
      resp.valid   = 1'b1;
      resp.fu_type = ARITH;
      resp.result  = a_result;
    end else if (m_done) begin
      resp.valid   = 1'b1;
      resp.fu_type = MUL;
      resp.result  = m_result;
    end else if (div_out) begin
      resp.valid     = 1'b1;
      resp.fu_type   = DIV;
      resp.result    = hold_valid ? hold_result : d_result;
      resp.exception = hold_valid ? hold_exc : d_zero;
    end
  end

  assign busy = d_busy || div_pending;  // low again after the DIV response

  // issuer spacing rule between ARITH and MUL
  assert property (@(posedge CLK) disable iff (!rst_n)
    !(a_done && m_done))
    else $error("vector_lane arith and mul results collide");

endmodule

//--- hdl/vector_lane_top.sv
//~~~~~~~~~~~~~~~~~~~~
// lane group top, LANES copies of vector_lane
// issue, fu_type and op are shared, vs1 and vs2 come per lane
// each lane returns its own tagged response and busy level
//~~~~~~~~~~~~~~~~~~~~

module vector_lane_top import vector_lane_pkg::*; (
  input  logic             CLK,
  input  logic             rst_n,
  input  logic             issue,
  input  fu_type_t         fu_type,
  input  alu_op_t          op,
  input  logic [XLEN-1:0]  vs1 [LANES],
  input  logic [XLEN-1:0]  vs2 [LANES],
  output lane_resp_t       resp [LANES],
  output logic [LANES-1:0] busy
);

  genvar i;

  generate
    for (i = 0; i < LANES; i++) begin : g_lane
      lane_req_t req;  // shared op, own operands

      assign req = '{fu_type: fu_type, op: op, vs1: vs1[i], vs2: vs2[i]};

      vector_lane u_vector_lane (
        .CLK   (CLK),
        .rst_n (rst_n),
        .issue (issue),
        .req   (req),
        .resp  (resp[i]),
        .busy  (busy[i])
      );
    end
  endgenerate

endmodule

//--- test/tb_vector_lane.sv
//~~~~~~~~~~~~~~~~~~~~
// testbench for the vector lane group top
// drives ARITH, MUL and DIV issues on all lanes and builds expected responses
// per lane from the operation rules for concurrent assertions to compare
// a cycle counter stops a hung run
//~~~~~~~~~~~~~~~~~~~~

module tb_vector_lane import vector_lane_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT_CYCLES = 4000;  // stimulus needs roughly 1500

  typedef struct packed {
    logic [31:0] due;   // cycle in which the response shows
    lane_resp_t  resp;
  } exp_entry_t;

  logic             CLK = 1'b0;
  logic             rst_n;
  logic             issue;
  fu_type_t         fu_type;
  alu_op_t          op;
  logic [XLEN-1:0]  vs1 [LANES];
  logic [XLEN-1:0]  vs2 [LANES];
  lane_resp_t       resp [LANES];
  logic [LANES-1:0] busy;

  int               cyc = 0;
  int               errors = 0;
  int               n_checked = 0;
  logic [XLEN-1:0]  rng = 32'd65;       // xorshift state
  logic [XLEN-1:0]  nxt_a [LANES];      // operands for the next issue
  logic [XLEN-1:0]  nxt_b [LANES];
  exp_entry_t       exp_q [LANES][$];   // arith and mul in completion order
  logic             div_pend [LANES];   // one divide in flight or parked
  int               div_issue [LANES];
  int               div_ready [LANES];
  lane_resp_t       div_resp [LANES];
  lane_resp_t       exp_resp [LANES];   // expected response this cycle
  logic [LANES-1:0] exp_busy = '0;

  vector_lane_top u_vector_lane_top (
    .CLK (CLK), .rst_n (rst_n), .issue (issue), .fu_type (fu_type), .op (op),
    .vs1 (vs1), .vs2 (vs2), .resp (resp), .busy (busy)
  );

  always #20 CLK = ~CLK;

  function automatic logic [XLEN-1:0] xorshift32(logic [XLEN-1:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // a quarter of the operands are corner values
  function automatic logic [XLEN-1:0] pick_operand();
    rng = xorshift32(rng);
    case (rng[3:0])
      4'd0:    return '0;
      4'd1:    return 32'd1;
      4'd2:    return '1;
      4'd3:    return 32'h8000_0000;  // most negative
      default: return rng;
    endcase
  endfunction

  // expected element result straight from the operation rules
  function automatic logic [XLEN-1:0] model_result(alu_op_t o, logic [XLEN-1:0] a,
                                                   logic [XLEN-1:0] b);
    logic signed [63:0] sa, sb;
    logic [63:0]        ua, ub;
    logic               ovf;
    sa  = $signed(a);  // sign extended to 64 bits
    sb  = $signed(b);
    ua  = {32'b0, a};
    ub  = {32'b0, b};
    ovf = a == 32'h8000_0000 && b == '1;
    case (o)
      ADD:    return a + b;
      SUB:    return a - b;
      AND:    return a & b;
      OR:     return a | b;
      XOR:    return a ^ b;
      SLL:    return a << b[4:0];
      SRL:    return a >> b[4:0];
      SRA:    return 32'(sa >> b[4:0]);  // upper half holds the sign copies
      MIN:    return (sa < sb) ? a : b;
      MINU:   return (a < b) ? a : b;
      MAX:    return (sa < sb) ? b : a;
      MAXU:   return (a < b) ? b : a;
      MULLO:  return 32'(ua * ub);
      MULHI:  return 32'((sa * sb) >> 32);
      MULHIU: return 32'((ua * ub) >> 32);
      DIVU:   return (b == '0) ? '1 : a / b;
      REMU:   return (b == '0) ? a : a % b;
      DIVS:   return (b == '0) ? '1 : ovf ? a : 32'(sa / sb);
      REMS:   return (b == '0) ? a : ovf ? '0 : 32'(sa % sb);
      default: return '0;
    endcase
  endfunction

  task automatic load_operands();
    for (int l = 0; l < LANES; l++) begin
      nxt_a[l] = pick_operand();
      nxt_b[l] = pick_operand();
    end
  endtask

  // drive one issue on the next edge and record what each lane owes
  task automatic issue_op(fu_type_t fu, alu_op_t o);
    exp_entry_t e;
    @(posedge CLK);
    issue   <= 1'b1;
    fu_type <= fu;
    op      <= o;
    for (int l = 0; l < LANES; l++) begin
      vs1[l] <= nxt_a[l];
      vs2[l] <= nxt_b[l];
      e.resp = '{valid: 1'b1, fu_type: fu, result: model_result(o, nxt_a[l], nxt_b[l]),
                 exception: fu == DIV && nxt_b[l] == '0};
      if (fu == DIV) begin
        div_pend[l]  = 1'b1;
        div_issue[l] = cyc + 1;   // issue is visible in the next cycle
        div_ready[l] = cyc + 34;  // done 33 cycles after issue
        div_resp[l]  = e.resp;
      end else begin
        e.due = cyc + (fu == ARITH ? 2 : 3);
        exp_q[l].push_back(e);
      end
    end
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge CLK);
      issue <= 1'b0;
    end
  endtask

  task automatic wait_not_busy();
    @(negedge CLK);  // sampled away from the edge
    while (busy != '0) begin
      @(negedge CLK);
    end
  endtask

  // expected response and busy for the cycle after this edge
  always @(posedge CLK) begin
    cyc <= cyc + 1;
    for (int l = 0; l < LANES; l++) begin
      exp_busy[l] <= rst_n && div_pend[l] && div_issue[l] < cyc + 1;
      exp_resp[l] <= '0;
      if (!rst_n) begin
        exp_resp[l] <= '0;
      end else if (exp_q[l].size() != 0 && exp_q[l][0].due == cyc + 1) begin
        exp_resp[l] <= exp_q[l][0].resp;
        void'(exp_q[l].pop_front());
        n_checked++;
      end else if (div_pend[l] && div_ready[l] <= cyc + 1) begin
        exp_resp[l] <= div_resp[l];  // first free cycle after done
        div_pend[l] = 1'b0;
        n_checked++;
      end
    end
  end

  for (genvar i = 0; i < LANES; i++) begin : g_chk
    assert property (@(posedge CLK) (!rst_n && cyc >= 2) |->
                     !resp[i].valid && !busy[i] && !resp[i].exception)
      else begin
        errors++;
        $display("CHECK FAILED lane %0d {resp.valid,busy,resp.exception} got %h expected 0",
                 i, {$sampled(resp[i].valid), $sampled(busy[i]),
                     $sampled(resp[i].exception)});
      end
    assert property (@(posedge CLK) disable iff (!rst_n) resp[i].valid == exp_resp[i].valid)
      else begin
        errors++;
        $display("CHECK FAILED lane %0d resp.valid got %h expected %h",
                 i, $sampled(resp[i].valid), $sampled(exp_resp[i].valid));
      end
    assert property (@(posedge CLK) disable iff (!rst_n)
                     exp_resp[i].valid |-> resp[i].fu_type == exp_resp[i].fu_type)
      else begin
        errors++;
        $display("CHECK FAILED lane %0d resp.fu_type got %h expected %h",
                 i, $sampled(resp[i].fu_type), $sampled(exp_resp[i].fu_type));
      end
    assert property (@(posedge CLK) disable iff (!rst_n)
                     exp_resp[i].valid |-> resp[i].result == exp_resp[i].result)
      else begin
        errors++;
        $display("CHECK FAILED lane %0d resp.result got %h expected %h",
                 i, $sampled(resp[i].result), $sampled(exp_resp[i].result));
      end
    assert property (@(posedge CLK) disable iff (!rst_n)
                     resp[i].exception == exp_resp[i].exception)
      else begin
        errors++;
        $display("CHECK FAILED lane %0d resp.exception got %h expected %h",
                 i, $sampled(resp[i].exception), $sampled(exp_resp[i].exception));
      end
    assert property (@(posedge CLK) disable iff (!rst_n) busy[i] == exp_busy[i])
      else begin
        errors++;
        $display("CHECK FAILED lane %0d busy got %h expected %h",
                 i, $sampled(busy[i]), $sampled(exp_busy[i]));
      end
  end

  always @(posedge CLK) begin
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, responses still missing", cyc);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    alu_op_t o;
    rst_n = 1'b0;
    issue = 1'b0;
    fu_type = ARITH;
    op = ADD;
    for (int l = 0; l < LANES; l++) begin
      vs1[l] = '0;
      vs2[l] = '0;
      div_pend[l] = 1'b0;
      exp_resp[l] = '0;
    end
    repeat (16) @(posedge CLK);
    rst_n <= 1'b1;
    idle(4);
    o = ADD;  // every ALU op six times
    repeat (12) begin
      repeat (6) begin
        load_operands();
        issue_op(ARITH, o);
      end
      o = o.next();
    end
    idle(2);
    o = MULLO;  // back to back multiplies
    repeat (3) begin
      repeat (20) begin
        load_operands();
        issue_op(MUL, o);
      end
      o = o.next();
    end
    idle(3);
    o = DIVS;
    repeat (4) begin
      for (int k = 0; k < 6; k++) begin
        load_operands();
        for (int l = 0; l < LANES; l++) begin
          if (k == 0) nxt_b[l] = '0;  // divide by zero everywhere
          if (k == 1) begin  // overflow
            nxt_a[l] = 32'h8000_0000;
            nxt_b[l] = '1;
          end
        end
        issue_op(DIV, o);
        idle(1);
        wait_not_busy();
      end
      // mul results land on done and the cycle after and then an arith
      load_operands();
      nxt_b[0] = '0;  // parked divide by zero in lane 0
      issue_op(DIV, o);
      idle(30);
      issue_op(MUL, MULHI);
      issue_op(MUL, MULLO);
      idle(1);
      issue_op(ARITH, ADD);
      idle(1);
      wait_not_busy();
      // steady mul stream across the whole divide
      issue_op(DIV, o);
      repeat (40) begin
        load_operands();
        issue_op(MUL, MULHIU);
      end
      idle(1);
      wait_not_busy();
      o = o.next();
    end
    idle(5);
    for (int l = 0; l < LANES; l++) begin
      if (exp_q[l].size() != 0 || div_pend[l]) begin
        errors++;
        $display("lane %0d: expected responses never appeared", l);
      end
    end
    $display("checked %0d responses, %0d errors", n_checked, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- filelist.f
hdl/vector_lane_pkg.sv
hdl/arithmetic_unit.sv
hdl/multiply_unit.sv
hdl/divide_unit.sv
hdl/vector_lane.sv
hdl/vector_lane_top.sv
test/tb_vector_lane.sv

//--- run_sim.sh
#!/bin/sh
# build the vector lane testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_vector_lane \
  -f filelist.f -o tb_vector_lane

status=0
./obj_dir/tb_vector_lane > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation passed"
